// File: common/llc_config.svh
/* llc directory sizing
   associativity, set count and tag width for one cache slice */

`ifndef LLC_CONFIG_SVH
`define LLC_CONFIG_SVH

// associativity
`define LLC_WAYS 8

// bits to index a way
`define LLC_WAY_BITS 3

// sets per slice
`define LLC_SETS 16

// bits to index a set
`define LLC_SET_BITS 4

// stored tag width
`define LLC_TAG_BITS 12

`endif

// File: common/llc_state_pkg.sv
/* llc coherence states
   encodings kept per way in the directory */

`default_nettype none

package llc_state_pkg;

    // per-way directory state
    typedef enum logic [1:0] {
        INVALID = 2'b00,
        VALID   = 2'b01,
        SHARED  = 2'b10,
        SD      = 2'b11
    } llc_state_t;

    // invalid means the way is free
    // SD is avoided as a victim when anything else is left

endpackage

`default_nettype wire

// File: common/llc_req_pkg.sv
/* llc request and address types
   set, tag and way words plus the request payload */

`default_nettype none

`include "llc_config.svh"

package llc_req_pkg;

    // way index
    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;

    // set index
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    // stored tag
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;

    // request travelling down the pipeline
    typedef struct packed {
        llc_set_t                  set;
        llc_tag_t                  tag;
        llc_state_pkg::llc_state_t new_state;
    } llc_req_t;

endpackage

`default_nettype wire

// File: source/llc_pipe_reg.sv
/* valid/ready pipeline register
   one entry, payload type set by parameter */

`timescale 1ns/1ps
`default_nettype none

module llc_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data,
    output logic     load
);

    // free slot, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: llc_lookup/llc_tag_store.sv
/* llc tag store
   per-set tags, states and eviction pointer with registered set read */

`timescale 1ns/1ps
`default_nettype none

`include "llc_config.svh"

module llc_tag_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_en,
    input  llc_req_pkg::llc_set_t     rd_set,
    output llc_req_pkg::llc_tag_t     rd_tags [`LLC_WAYS],
    output llc_state_pkg::llc_state_t rd_states [`LLC_WAYS],
    output llc_req_pkg::llc_way_t     rd_evict_way,
    input  logic                      wr_en,
    input  llc_req_pkg::llc_set_t     wr_set,
    input  llc_req_pkg::llc_way_t     wr_way,
    input  llc_req_pkg::llc_tag_t     wr_tag,
    input  llc_state_pkg::llc_state_t wr_state,
    input  logic                      wr_ptr_en,
    input  llc_req_pkg::llc_way_t     wr_ptr
);

    llc_req_pkg::llc_tag_t     tags [`LLC_SETS][`LLC_WAYS];
    llc_state_pkg::llc_state_t states [`LLC_SETS][`LLC_WAYS];
    llc_req_pkg::llc_way_t     evict_ptrs [`LLC_SETS];

    // tag array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_set][wr_way] <= wr_tag;
        end
    end

    // states and pointers start out empty
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_ptrs[s] <= '0;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    states[s][w] <= llc_state_pkg::INVALID;
                end
            end
        end else begin
            if (wr_en) begin
                states[wr_set][wr_way] <= wr_state;
            end
            if (wr_ptr_en) begin
                evict_ptrs[wr_set] <= wr_ptr;
            end
        end
    end

    // whole set captured on read, held until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tags      <= tags[rd_set];
            rd_states    <= states[rd_set];
            rd_evict_way <= evict_ptrs[rd_set];
        end
    end

endmodule

`default_nettype wire

// File: llc_lookup/llc_lookup_way.sv
/* llc way lookup
   picks hit, empty or victim way for a set and flops the choice */

`timescale 1ns/1ps
`default_nettype none

`include "llc_config.svh"

module llc_lookup_way (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      lookup_en,
    input  llc_req_pkg::llc_tag_t     tag,
    input  var llc_req_pkg::llc_tag_t tags_buf [`LLC_WAYS],
    input  var llc_state_pkg::llc_state_t states_buf [`LLC_WAYS],
    input  llc_req_pkg::llc_way_t     evict_way_buf,
    output logic                      evict,
    output logic                      evict_next,
    output llc_req_pkg::llc_way_t     way,
    output llc_req_pkg::llc_way_t     way_next
);

    logic [`LLC_WAYS-1:0]  hit_mask;
    logic [`LLC_WAYS-1:0]  empty_mask;
    logic [`LLC_WAYS-1:0]  valid_mask;
    logic [`LLC_WAYS-1:0]  not_sd_mask;
    llc_req_pkg::llc_way_t rot_way [`LLC_WAYS];

    llc_req_pkg::llc_way_t hit_way;
    llc_req_pkg::llc_way_t empty_way;
    llc_req_pkg::llc_way_t valid_way;
    llc_req_pkg::llc_way_t not_sd_way;

    // victim masks are indexed by distance from the pointer
    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            rot_way[i]     = llc_req_pkg::llc_way_t'(i) + evict_way_buf;
            hit_mask[i]    = (tags_buf[i] == tag) &&
                             (states_buf[i] != llc_state_pkg::INVALID);
            empty_mask[i]  = (states_buf[i] == llc_state_pkg::INVALID);
            valid_mask[i]  = (states_buf[rot_way[i]] == llc_state_pkg::VALID);
            not_sd_mask[i] = (states_buf[rot_way[i]] != llc_state_pkg::SD);
        end
    end

    // lowest set bit wins, scanned from the top down
    always_comb begin
        hit_way    = '0;
        empty_way  = '0;
        valid_way  = evict_way_buf;
        not_sd_way = evict_way_buf;
        for (int j = `LLC_WAYS - 1; j >= 0; j--) begin
            if (hit_mask[j]) begin
                hit_way = llc_req_pkg::llc_way_t'(j);
            end
            if (empty_mask[j]) begin
                empty_way = llc_req_pkg::llc_way_t'(j);
            end
            if (valid_mask[j]) begin
                valid_way = rot_way[j];
            end
            if (not_sd_mask[j]) begin
                not_sd_way = rot_way[j];
            end
        end
    end

    always_comb begin
        if (|hit_mask) begin
            way_next   = hit_way;
            evict_next = 1'b0;
        end else if (|empty_mask) begin
            way_next   = empty_way;
            evict_next = 1'b0;
        end else if (|valid_mask) begin
            way_next   = valid_way;
            evict_next = 1'b1;
        end else if (|not_sd_mask) begin
            way_next   = not_sd_way;
            evict_next = 1'b1;
        end else begin
            // every way is SD, take the pointer
            way_next   = evict_way_buf;
            evict_next = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way   <= '0;
            evict <= 1'b0;
        end else if (lookup_en) begin
            way   <= way_next;
            evict <= evict_next;
        end
    end

endmodule

`default_nettype wire

// File: source/llc_update.sv
/* llc update and respond stage
   holds one response, writes the way and pointer when it is taken */

`timescale 1ns/1ps
`default_nettype none

`include "llc_config.svh"

module llc_update (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  llc_req_pkg::llc_set_t         in_set,
    input  llc_req_pkg::llc_tag_t         in_tag,
    input  llc_state_pkg::llc_state_t     in_new_state,
    input  llc_req_pkg::llc_way_t         in_way,
    input  logic                          in_evict,
    input  var llc_req_pkg::llc_tag_t     in_old_tags [`LLC_WAYS],
    input  var llc_state_pkg::llc_state_t in_old_states [`LLC_WAYS],
    output logic                          wr_en,
    output llc_req_pkg::llc_set_t         wr_set,
    output llc_req_pkg::llc_way_t         wr_way,
    output llc_req_pkg::llc_tag_t         wr_tag,
    output llc_state_pkg::llc_state_t     wr_state,
    output logic                          wr_ptr_en,
    output llc_req_pkg::llc_way_t         wr_ptr,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic                          rsp_hit,
    output logic                          rsp_evict,
    output llc_req_pkg::llc_way_t         rsp_way,
    output llc_req_pkg::llc_tag_t         rsp_old_tag,
    output llc_state_pkg::llc_state_t     rsp_old_state
);

    logic                      take;
    logic                      rsp_xfer;
    llc_req_pkg::llc_tag_t     old_tag_sel;
    llc_state_pkg::llc_state_t old_state_sel;
    logic                      hit_next;

    assign in_ready = !rsp_valid || rsp_ready;
    assign take     = in_valid && in_ready;
    assign rsp_xfer = rsp_valid && rsp_ready;

    // old contents of the chosen way
    assign old_tag_sel   = in_old_tags[in_way];
    assign old_state_sel = in_old_states[in_way];
    assign hit_next      = !in_evict && (old_tag_sel == in_tag) &&
                           (old_state_sel != llc_state_pkg::INVALID);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid <= 1'b0;
        end else if (in_ready) begin
            rsp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_set        <= in_set;
            wr_tag        <= in_tag;
            wr_state      <= in_new_state;
            rsp_way       <= in_way;
            rsp_evict     <= in_evict;
            rsp_hit       <= hit_next;
            rsp_old_tag   <= old_tag_sel;
            rsp_old_state <= old_state_sel;
        end
    end

    // store is written as the response goes out
    assign wr_en     = rsp_xfer;
    assign wr_way    = rsp_way;
    assign wr_ptr_en = rsp_xfer && rsp_evict;
    assign wr_ptr    = (rsp_way == `LLC_WAYS - 1) ? '0 : rsp_way + 1'b1;

endmodule

`default_nettype wire

// File: source/llc_lookup_top.sv
/* llc directory lookup pipeline
   accept and read, lookup, update and respond, with same-set stall */

`timescale 1ns/1ps
`default_nettype none

`include "llc_config.svh"

module llc_lookup_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  llc_req_pkg::llc_set_t     req_set,
    input  llc_req_pkg::llc_tag_t     req_tag,
    input  llc_state_pkg::llc_state_t req_new_state,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic                      rsp_hit,
    output logic                      rsp_evict,
    output llc_req_pkg::llc_way_t     rsp_way,
    output llc_req_pkg::llc_tag_t     rsp_old_tag,
    output llc_state_pkg::llc_state_t rsp_old_state
);

    llc_req_pkg::llc_req_t     req_data;
    llc_req_pkg::llc_req_t     s1_data;
    llc_req_pkg::llc_req_t     s2_data;
    logic                      s1_in_valid;
    logic                      s1_in_ready;
    logic                      s1_valid;
    logic                      s1_load;
    logic                      s2_in_ready;
    logic                      s2_valid;
    logic                      s2_load;
    logic                      upd_in_ready;
    logic                      busy;
    llc_req_pkg::llc_tag_t     rd_tags [`LLC_WAYS];
    llc_state_pkg::llc_state_t rd_states [`LLC_WAYS];
    llc_req_pkg::llc_way_t     rd_evict_way;
    llc_req_pkg::llc_tag_t     tags_s2 [`LLC_WAYS];
    llc_state_pkg::llc_state_t states_s2 [`LLC_WAYS];
    llc_req_pkg::llc_way_t     lk_way;
    logic                      lk_evict;
    logic                      wr_en;
    llc_req_pkg::llc_set_t     wr_set;
    llc_req_pkg::llc_way_t     wr_way;
    llc_req_pkg::llc_tag_t     wr_tag;
    llc_state_pkg::llc_state_t wr_state;
    logic                      wr_ptr_en;
    llc_req_pkg::llc_way_t     wr_ptr;

    assign req_data = '{set: req_set, tag: req_tag, new_state: req_new_state};

    // hold off a set that still has a request in flight
    assign busy = (s1_valid && (s1_data.set == req_set)) ||
                  (s2_valid && (s2_data.set == req_set)) ||
                  (rsp_valid && (wr_set == req_set));

    assign s1_in_valid = req_valid && !busy;
    assign req_ready   = s1_in_ready && !busy;

    llc_pipe_reg #(.payload_t(llc_req_pkg::llc_req_t)) s1_reg (
        .clk(clk), .rst(rst),
        .in_valid(s1_in_valid), .in_ready(s1_in_ready), .in_data(req_data),
        .out_valid(s1_valid), .out_ready(s2_in_ready), .out_data(s1_data),
        .load(s1_load)
    );

    llc_tag_store u_tag_store (
        .clk(clk), .rst(rst),
        .rd_en(s1_load), .rd_set(req_set),
        .rd_tags(rd_tags), .rd_states(rd_states), .rd_evict_way(rd_evict_way),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way),
        .wr_tag(wr_tag), .wr_state(wr_state),
        .wr_ptr_en(wr_ptr_en), .wr_ptr(wr_ptr)
    );

    // choice is flopped as the request moves into s2
    llc_lookup_way u_lookup_way (
        .clk(clk), .rst(rst), .lookup_en(s2_load), .tag(s1_data.tag),
        .tags_buf(rd_tags), .states_buf(rd_states), .evict_way_buf(rd_evict_way),
        .evict(lk_evict), .evict_next(), .way(lk_way), .way_next()
    );

    llc_pipe_reg #(.payload_t(llc_req_pkg::llc_req_t)) s2_reg (
        .clk(clk), .rst(rst),
        .in_valid(s1_valid), .in_ready(s2_in_ready), .in_data(s1_data),
        .out_valid(s2_valid), .out_ready(upd_in_ready), .out_data(s2_data),
        .load(s2_load)
    );

    // read data aligned with s2
    always_ff @(posedge clk) begin
        if (s2_load) begin
            tags_s2   <= rd_tags;
            states_s2 <= rd_states;
        end
    end

    llc_update u_update (
        .clk(clk), .rst(rst),
        .in_valid(s2_valid), .in_ready(upd_in_ready),
        .in_set(s2_data.set), .in_tag(s2_data.tag), .in_new_state(s2_data.new_state),
        .in_way(lk_way), .in_evict(lk_evict),
        .in_old_tags(tags_s2), .in_old_states(states_s2),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_tag(wr_tag),
        .wr_state(wr_state), .wr_ptr_en(wr_ptr_en), .wr_ptr(wr_ptr),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .rsp_hit(rsp_hit), .rsp_evict(rsp_evict), .rsp_way(rsp_way),
        .rsp_old_tag(rsp_old_tag), .rsp_old_state(rsp_old_state)
    );

endmodule

`default_nettype wire

// File: dv/llc_lookup_tb.sv
/* llc directory lookup testbench
   directed fills, hits and evictions, then random traffic checked against a model */

`timescale 1ns/1ps
`default_nettype none

`include "llc_config.svh"

module llc_lookup_tb;

    typedef struct packed {
        logic                      hit;
        logic                      evict;
        llc_req_pkg::llc_way_t     way;
        llc_req_pkg::llc_tag_t     old_tag;
        llc_state_pkg::llc_state_t old_state;
        logic                      tag_known;
        logic                      lat_check;
        logic [31:0]               cycle;
    } rsp_exp_t;

    // way 7 down to way 0 holds SHARED VALID SD SHARED SD VALID SHARED SD
    localparam logic [15:0] fill_states = 16'b10_01_11_10_11_01_10_11;

    logic                      clk;
    logic                      rst;
    logic                      req_valid;
    logic                      req_ready;
    llc_req_pkg::llc_set_t     req_set;
    llc_req_pkg::llc_tag_t     req_tag;
    llc_state_pkg::llc_state_t req_new_state;
    logic                      rsp_valid;
    logic                      rsp_ready;
    logic                      rsp_hit;
    logic                      rsp_evict;
    llc_req_pkg::llc_way_t     rsp_way;
    llc_req_pkg::llc_tag_t     rsp_old_tag;
    llc_state_pkg::llc_state_t rsp_old_state;

    integer      seed;
    int          mismatch_count;
    int          fail_count;
    int          accept_count;
    logic [31:0] cycle_count;
    logic [31:0] last_accept_cycle;
    logic [31:0] first_cycle;
    logic        rsp_random;
    logic        lat_mode;
    rsp_exp_t    exp_q [$];

    // shadow directory
    llc_req_pkg::llc_tag_t     m_tags [`LLC_SETS][`LLC_WAYS];
    llc_state_pkg::llc_state_t m_states [`LLC_SETS][`LLC_WAYS];
    logic                      m_written [`LLC_SETS][`LLC_WAYS];
    llc_req_pkg::llc_way_t     m_ptr [`LLC_SETS];

    llc_lookup_top dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_set(req_set),
        .req_tag(req_tag), .req_new_state(req_new_state),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_hit(rsp_hit),
        .rsp_evict(rsp_evict), .rsp_way(rsp_way), .rsp_old_tag(rsp_old_tag),
        .rsp_old_state(rsp_old_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] act,
                                 input logic [31:0] expected);
        if (act !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, act, expected);
        end
    endtask

    task automatic clear_model;
        for (int s = 0; s < `LLC_SETS; s++) begin
            m_ptr[s] = '0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                m_tags[s][w]    = '0;
                m_states[s][w]  = llc_state_pkg::INVALID;
                m_written[s][w] = 1'b0;
            end
        end
    endtask

    // hit, then lowest empty, then VALID from the pointer, then non-SD, then the pointer
    function automatic rsp_exp_t predict_rsp(input int set, input llc_req_pkg::llc_tag_t tag,
                                             input llc_state_pkg::llc_state_t new_state);
        rsp_exp_t e;
        int       w;
        logic     found;
        e     = '0;
        found = 1'b0;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (!found && m_states[set][i] != llc_state_pkg::INVALID && m_tags[set][i] == tag) begin
                found = 1'b1;
                e.hit = 1'b1;
                e.way = llc_req_pkg::llc_way_t'(i);
            end
        end
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (!found && m_states[set][i] == llc_state_pkg::INVALID) begin
                found = 1'b1;
                e.way = llc_req_pkg::llc_way_t'(i);
            end
        end
        for (int d = 0; d < `LLC_WAYS; d++) begin
            w = (int'(m_ptr[set]) + d) % `LLC_WAYS;
            if (!found && m_states[set][w] == llc_state_pkg::VALID) begin
                found   = 1'b1;
                e.evict = 1'b1;
                e.way   = llc_req_pkg::llc_way_t'(w);
            end
        end
        for (int d = 0; d < `LLC_WAYS; d++) begin
            w = (int'(m_ptr[set]) + d) % `LLC_WAYS;
            if (!found && m_states[set][w] != llc_state_pkg::SD) begin
                found   = 1'b1;
                e.evict = 1'b1;
                e.way   = llc_req_pkg::llc_way_t'(w);
            end
        end
        if (!found) begin
            e.evict = 1'b1;
            e.way   = m_ptr[set];
        end
        e.old_tag   = m_tags[set][e.way];
        e.old_state = m_states[set][e.way];
        e.tag_known = m_written[set][e.way];
        m_tags[set][e.way]    = tag;
        m_states[set][e.way]  = new_state;
        m_written[set][e.way] = 1'b1;
        if (e.evict) begin
            m_ptr[set] = llc_req_pkg::llc_way_t'((int'(e.way) + 1) % `LLC_WAYS);
        end
        return e;
    endfunction

    // compare responses in order and record accepted requests
    always @(posedge clk) begin
        rsp_exp_t e;
        if (rst) begin
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    fail_count++;
                    $display("response arrived with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    compare_value("rsp_hit", rsp_hit, e.hit);
                    compare_value("rsp_evict", rsp_evict, e.evict);
                    compare_value("rsp_way", rsp_way, e.way);
                    compare_value("rsp_old_state", rsp_old_state, e.old_state);
                    if (e.tag_known) begin
                        compare_value("rsp_old_tag", rsp_old_tag, e.old_tag);
                    end
                    if (e.lat_check) begin
                        compare_value("rsp latency", cycle_count - e.cycle, 3);
                    end
                end
            end
            if (req_valid && req_ready) begin
                e           = predict_rsp(req_set, req_tag, req_new_state);
                e.cycle     = cycle_count;
                e.lat_check = lat_mode;
                exp_q.push_back(e);
                accept_count++;
                last_accept_cycle = cycle_count;
            end
            cycle_count++;
        end
    end

    // random back-pressure drawn on the rising edge and driven on the falling one
    initial begin
        logic gap;
        forever begin
            @(posedge clk);
            gap = rsp_random && (($random(seed) & 3) == 0);
            @(negedge clk);
            rsp_ready = !gap;
        end
    end

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_req(input int set, input int tag, input llc_state_pkg::llc_state_t st);
        int start;
        int waited;
        start         = accept_count;
        waited        = 0;
        req_valid     = 1'b1;
        req_set       = llc_req_pkg::llc_set_t'(set);
        req_tag       = llc_req_pkg::llc_tag_t'(tag);
        req_new_state = st;
        while (accept_count == start && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (accept_count == start) begin
            fail_count++;
            $display("timeout: request to set %0d was never accepted", set);
        end
        req_valid = 1'b0;
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            fail_count++;
            $display("timeout: %0d responses never arrived", exp_q.size());
        end
    endtask

    initial begin
        int set;
        seed              = 76437;
        rst               = 1'b0;
        req_valid         = 1'b0;
        req_set           = '0;
        req_tag           = '0;
        req_new_state     = llc_state_pkg::INVALID;
        rsp_ready         = 1'b1;
        rsp_random        = 1'b0;
        lat_mode          = 1'b0;
        mismatch_count    = 0;
        fail_count        = 0;
        accept_count      = 0;
        cycle_count       = '0;
        last_accept_cycle = '0;
        first_cycle       = '0;
        set               = 0;
        clear_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        compare_value("req_ready", req_ready, 1);
        compare_value("rsp_valid", rsp_valid, 0);

        // empty set fills ways in ascending order
        for (int i = 0; i < `LLC_WAYS; i++) begin
            send_req(3, 'h100 + i, llc_state_pkg::VALID);
        end
        wait_drain();

        // a hit on a present tag shows its new state as the old state next time
        send_req(3, 'h103, llc_state_pkg::SHARED);
        send_req(3, 'h103, llc_state_pkg::VALID);
        wait_drain();

        // misses into a full set of mixed states walk the victim order
        for (int i = 0; i < `LLC_WAYS; i++) begin
            send_req(5, 'h200 + i, llc_state_pkg::llc_state_t'(fill_states[2*i +: 2]));
        end
        for (int i = 0; i < `LLC_WAYS; i++) begin
            send_req(5, 'h2f0 + i, llc_state_pkg::SD);
        end
        wait_drain();

        // invalidated way becomes the next empty way
        send_req(5, 'h2f4, llc_state_pkg::INVALID);
        send_req(5, 'h2aa, llc_state_pkg::VALID);
        wait_drain();

        // random sets with repeats and a small tag pool for hits
        rsp_random = 1'b1;
        for (int i = 0; i < 400; i++) begin
            if (($random(seed) & 3) != 0) begin
                set = $random(seed) & 15;
            end
            send_req(set, 'h300 | ($random(seed) & 15),
                     llc_state_pkg::llc_state_t'($random(seed) & 3));
        end
        rsp_random = 1'b0;
        wait_drain();

        // distinct sets stream at one per cycle
        lat_mode = 1'b1;
        for (int i = 0; i < `LLC_SETS; i++) begin
            send_req(i, 'h400 + i, llc_state_pkg::SHARED);
            if (i == 0) begin
                first_cycle = last_accept_cycle;
            end
        end
        compare_value("accept span", last_accept_cycle - first_cycle, `LLC_SETS - 1);
        wait_drain();
        lat_mode = 1'b0;

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: llc_lookup_top.f
+incdir+common
common/llc_state_pkg.sv
common/llc_req_pkg.sv
source/llc_pipe_reg.sv
llc_lookup/llc_tag_store.sv
llc_lookup/llc_lookup_way.sv
source/llc_update.sv
source/llc_lookup_top.sv
dv/llc_lookup_tb.sv

// File: Bender.yml
package:
  name: llc_lookup

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/llc_state_pkg.sv
      - common/llc_req_pkg.sv
      - source/llc_pipe_reg.sv
      - llc_lookup/llc_tag_store.sv
      - llc_lookup/llc_lookup_way.sv
      - source/llc_update.sv
      - source/llc_lookup_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/llc_lookup_tb.sv
